/* logic/axi_defs_pkg.sv */
package axi_defs_pkg;

	////////////////////
	// bus widths
	////////////////////
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int id_w   = 4;
	localparam int len_w  = 8;

	// AR field codes, single beat only
	localparam logic [2:0] size_word   = 3'b010;
	localparam logic [1:0] burst_fixed = 2'b00;

	// response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// one-hot channel states of the read master
	localparam logic [1:0] ar_idle = 2'b01;
	localparam logic [1:0] ar_req  = 2'b10;
	localparam logic [1:0] r_idle  = 2'b01;
	localparam logic [1:0] r_xfer  = 2'b10;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [len_w-1:0]  len;
		logic [2:0]        size;
		logic [1:0]        burst;
		logic [id_w-1:0]   id;
	} ar_beat_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [1:0]        resp;
		logic              last;
		logic [id_w-1:0]   id;
	} r_beat_t;

endpackage

/* logic/cpu_defs_pkg.sv */
package cpu_defs_pkg;

	// word address drops the two byte offset bits
	localparam int word_w = axi_defs_pkg::addr_w - 2;

	// load size codes
	localparam logic [1:0] ld_byte = 2'd0;
	localparam logic [1:0] ld_half = 2'd1;
	localparam logic [1:0] ld_word = 2'd2;

	typedef logic [1:0] ld_size_t;

	typedef struct packed {
		logic [axi_defs_pkg::addr_w-1:0] addr;
		logic [axi_defs_pkg::id_w-1:0]   id;
		ld_size_t                        size;
		logic                            sgn;
	} load_req_t;

	typedef struct packed {
		logic [axi_defs_pkg::data_w-1:0] data;
		logic [axi_defs_pkg::id_w-1:0]   id;
		logic                            err;
	} load_res_t;

	// level from the write path, word address of the store in progress
	typedef struct packed {
		logic              busy;
		logic [word_w-1:0] waddr;
	} store_note_t;

	// one data word seen as byte lanes or as halfword lanes
	typedef union packed {
		logic [axi_defs_pkg::data_w/8-1:0][7:0]   b;
		logic [axi_defs_pkg::data_w/16-1:0][15:0] h;
	} lane_word_u;

endpackage

/* logic/load_req_gate.sv */
`timescale 1ns/10ps

module load_req_gate (
	input  logic                      ACLK,
	input  logic                      ARESETn,
	input  logic                      ren,
	input  cpu_defs_pkg::load_req_t   req,
	input  cpu_defs_pkg::store_note_t store,
	input  logic                      done,
	output logic                      req_ready,
	output logic                      raddr_ok,
	output logic                      pend,
	output cpu_defs_pkg::load_req_t   pend_req,
	output logic                      hazard
);

	logic                            accept;
	logic [cpu_defs_pkg::word_w-1:0] pend_word;

	////////////////////
	// request capture
	////////////////////

	// a strobe counts only while the gate is free
	assign accept    = ren && req_ready;
	assign req_ready = !pend;

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			pend     <= 1'b0;
			raddr_ok <= 1'b0;
		end else begin
			raddr_ok <= accept;
			if (accept) begin
				pend <= 1'b1;
			end else if (done) begin
				pend <= 1'b0;
			end
		end
	end

	// request held until the read completes
	always_ff @(posedge ACLK) begin
		if (accept) begin
			pend_req <= req;
		end
	end

	////////////////////
	// store hazard
	////////////////////

	// compare on word granularity, the store may touch any lane
	assign pend_word = pend_req.addr[axi_defs_pkg::addr_w-1:2];

	always_comb begin
		hazard = 1'b0;
		if (pend && store.busy) begin
			hazard = (store.waddr == pend_word);
		end
	end

endmodule

/* logic/axi_rd_master.sv */
`timescale 1ns/10ps

module axi_rd_master (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  logic                    pend,
	input  cpu_defs_pkg::load_req_t pend_req,
	input  logic                    hazard,
	output axi_defs_pkg::ar_beat_t  ar,
	output logic                    ARVALID,
	input  logic                    ARREADY,
	input  axi_defs_pkg::r_beat_t   r,
	input  logic                    RVALID,
	output logic                    RREADY,
	output logic                    beat,
	output axi_defs_pkg::r_beat_t   beat_data,
	output logic                    done
);

	logic       ar_hs;
	logic       r_hs;
	logic       issue;
	logic [1:0] ar_state;
	logic [1:0] ar_next;
	logic [1:0] r_state;
	logic [1:0] r_next;

	assign ar_hs = ARVALID && ARREADY;
	assign r_hs  = RVALID && RREADY;

	// launch when a request waits, nothing is in flight and no store clashes
	assign issue = pend && !hazard && ar_state[0] && r_state[0];

	////////////////////
	// address channel
	////////////////////

	always_comb begin
		case (ar_state)
			axi_defs_pkg::ar_idle: begin
				if (issue) begin
					ar_next = axi_defs_pkg::ar_req;
				end else begin
					ar_next = axi_defs_pkg::ar_idle;
				end
			end
			axi_defs_pkg::ar_req: begin
				if (ar_hs) begin
					ar_next = axi_defs_pkg::ar_idle;
				end else begin
					ar_next = axi_defs_pkg::ar_req;
				end
			end
			default: begin
				ar_next = axi_defs_pkg::ar_idle;
			end
		endcase
	end

	// valid comes straight from the state flop so it cannot drop while waiting
	assign ARVALID = ar_state[1];

	// one word-aligned beat, len 0, fixed burst
	always_ff @(posedge ACLK) begin
		if (issue) begin
			ar.addr  <= {pend_req.addr[axi_defs_pkg::addr_w-1:2], 2'b00};
			ar.len   <= '0;
			ar.size  <= axi_defs_pkg::size_word;
			ar.burst <= axi_defs_pkg::burst_fixed;
			ar.id    <= pend_req.id;
		end
	end

	////////////////////
	// data channel
	////////////////////

	always_comb begin
		case (r_state)
			axi_defs_pkg::r_idle: begin
				if (ar_hs) begin
					r_next = axi_defs_pkg::r_xfer;
				end else begin
					r_next = axi_defs_pkg::r_idle;
				end
			end
			axi_defs_pkg::r_xfer: begin
				// a stray non-last beat keeps the channel open
				if (r_hs && r.last) begin
					r_next = axi_defs_pkg::r_idle;
				end else begin
					r_next = axi_defs_pkg::r_xfer;
				end
			end
			default: begin
				r_next = axi_defs_pkg::r_idle;
			end
		endcase
	end

	assign RREADY = r_state[1];

	////////////////////
	// state registers
	////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			ar_state <= axi_defs_pkg::ar_idle;
			r_state  <= axi_defs_pkg::r_idle;
		end else begin
			ar_state <= ar_next;
			r_state  <= r_next;
		end
	end

	// last beat taken, hand data on and free the gate
	assign beat      = r_hs && r.last;
	assign beat_data = r;
	assign done      = beat;

endmodule

/* logic/load_result_align.sv */
`timescale 1ns/10ps

module load_result_align (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  logic                    beat,
	input  axi_defs_pkg::r_beat_t   beat_data,
	input  logic [1:0]              offs,
	input  cpu_defs_pkg::ld_size_t  size,
	input  logic                    sgn,
	output logic                    rdata_ok,
	output cpu_defs_pkg::load_res_t res
);

	cpu_defs_pkg::lane_word_u        word;
	logic [7:0]                      sel_b;
	logic [15:0]                     sel_h;
	logic [axi_defs_pkg::data_w-1:0] ext;

	////////////////////
	// lane select
	////////////////////

	assign word = beat_data.data;

	// byte by full offset, halfword by offs[1] only
	assign sel_b = word.b[offs];
	assign sel_h = word.h[offs[1]];

	always_comb begin
		case (size)
			cpu_defs_pkg::ld_byte: begin
				ext = {{(axi_defs_pkg::data_w-8){sgn && sel_b[7]}}, sel_b};
			end
			cpu_defs_pkg::ld_half: begin
				ext = {{(axi_defs_pkg::data_w-16){sgn && sel_h[15]}}, sel_h};
			end
			default: begin
				// full word, nothing to extend
				ext = beat_data.data;
			end
		endcase
	end

	////////////////////
	// result register
	////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			rdata_ok <= 1'b0;
		end else begin
			rdata_ok <= beat;
		end
	end

	// any response other than okay flags the load
	always_ff @(posedge ACLK) begin
		if (beat) begin
			res.data <= ext;
			res.id   <= beat_data.id;
			res.err  <= (beat_data.resp != axi_defs_pkg::resp_okay);
		end
	end

endmodule

/* logic/axi_rd_bridge_top.sv */
`timescale 1ns/10ps

module axi_rd_bridge_top (
	input  logic                      ACLK,
	input  logic                      ARESETn,
	// processor load port
	input  logic                      ren,
	input  cpu_defs_pkg::load_req_t   req,
	output logic                      req_ready,
	output logic                      raddr_ok,
	input  cpu_defs_pkg::store_note_t store,
	output logic                      rdata_ok,
	output cpu_defs_pkg::load_res_t   res,
	// AXI read channels
	output axi_defs_pkg::ar_beat_t    ar,
	output logic                      ARVALID,
	input  logic                      ARREADY,
	input  axi_defs_pkg::r_beat_t     r,
	input  logic                      RVALID,
	output logic                      RREADY
);

	logic                    pend;
	logic                    hazard;
	logic                    done;
	logic                    beat;
	cpu_defs_pkg::load_req_t pend_req;
	axi_defs_pkg::r_beat_t   beat_data;

	load_req_gate gate_i (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.ren       (ren),
		.req       (req),
		.store     (store),
		.done      (done),
		.req_ready (req_ready),
		.raddr_ok  (raddr_ok),
		.pend      (pend),
		.pend_req  (pend_req),
		.hazard    (hazard)
	);

	axi_rd_master master_i (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.pend      (pend),
		.pend_req  (pend_req),
		.hazard    (hazard),
		.ar        (ar),
		.ARVALID   (ARVALID),
		.ARREADY   (ARREADY),
		.r         (r),
		.RVALID    (RVALID),
		.RREADY    (RREADY),
		.beat      (beat),
		.beat_data (beat_data),
		.done      (done)
	);

	// offset and size stay valid in the gate until done
	load_result_align align_i (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.beat      (beat),
		.beat_data (beat_data),
		.offs      (pend_req.addr[1:0]),
		.size      (pend_req.size),
		.sgn       (pend_req.sgn),
		.rdata_ok  (rdata_ok),
		.res       (res)
	);

endmodule

/* dv/axi_rd_slave_model.sv */
`timescale 1ns/10ps

module axi_rd_slave_model (
	input  logic                   ACLK,
	input  logic                   ARESETn,
	input  axi_defs_pkg::ar_beat_t ar,
	input  logic                   ARVALID,
	output logic                   ARREADY,
	output axi_defs_pkg::r_beat_t  r,
	output logic                   RVALID,
	input  logic                   RREADY
);

	logic [31:0]                     rng;
	logic [1:0]                      ar_wait;
	logic [1:0]                      r_wait;
	logic                            busy;
	logic [axi_defs_pkg::addr_w-1:0] rd_addr;
	logic [axi_defs_pkg::id_w-1:0]   rd_id;

	function automatic logic [31:0] lcg_step(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// memory contents, a scramble of the whole word address
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return lcg_step(lcg_step({a[31:2], 2'b00} ^ 32'he287_f19f));
	endfunction

	////////////////////
	// channel timing
	////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			rng     <= 32'he287_f19f;
			ar_wait <= 2'd0;
			r_wait  <= 2'd0;
			busy    <= 1'b0;
			rd_addr <= '0;
			rd_id   <= '0;
		end else begin
			if (ARVALID && ARREADY) begin
				busy    <= 1'b1;
				rd_addr <= ar.addr;
				rd_id   <= ar.id;
				r_wait  <= rng[17:16];
				rng     <= lcg_step(rng);
			end else if (!busy && ar_wait != 2'd0) begin
				// ready comes back on its own, with or without a request
				ar_wait <= ar_wait - 2'd1;
			end
			if (RVALID && RREADY) begin
				busy    <= 1'b0;
				ar_wait <= rng[25:24];
			end else if (busy && r_wait != 2'd0) begin
				r_wait <= r_wait - 2'd1;
			end
		end
	end

	assign ARREADY = !busy && (ar_wait == 2'd0);
	assign RVALID  = busy && (r_wait == 2'd0);

	// upper half of the map answers with slave error
	always_comb begin
		r.data = fill_word(rd_addr);
		r.resp = rd_addr[31] ? axi_defs_pkg::resp_slverr : axi_defs_pkg::resp_okay;
		r.last = 1'b1;
		r.id   = rd_id;
	end

endmodule

/* dv/axi_rd_bridge_tb.sv */
`timescale 1ns/10ps

module axi_rd_bridge_tb;

	// loads issued over all tests, 40 cycles each plus reset and hazard hold
	localparam int n_loads = 228;
	localparam int budget_ns = (n_loads * 40 + 2000) * 20;

	logic                      ACLK;
	logic                      ARESETn;
	logic                      ren;
	cpu_defs_pkg::load_req_t   req;
	logic                      req_ready;
	logic                      raddr_ok;
	cpu_defs_pkg::store_note_t store;
	logic                      rdata_ok;
	cpu_defs_pkg::load_res_t   res;
	axi_defs_pkg::ar_beat_t    ar;
	logic                      ARVALID;
	logic                      ARREADY;
	axi_defs_pkg::r_beat_t     r;
	logic                      RVALID;
	logic                      RREADY;

	cpu_defs_pkg::load_res_t exp_q[$];
	cpu_defs_pkg::load_res_t exp_res;
	logic [31:0]             rng;
	logic [3:0]              next_id;
	logic                    block_chk;
	int                      err_cnt;
	int                      test_err0;
	int                      tests_ok;
	int                      tests_bad;
	int                      accept_cnt;
	int                      raddr_cnt;
	int                      cyc;

	axi_rd_bridge_top axi_rd_bridge_top_i (
		.ACLK(ACLK), .ARESETn(ARESETn), .ren(ren), .req(req),
		.req_ready(req_ready), .raddr_ok(raddr_ok), .store(store),
		.rdata_ok(rdata_ok), .res(res), .ar(ar), .ARVALID(ARVALID),
		.ARREADY(ARREADY), .r(r), .RVALID(RVALID), .RREADY(RREADY)
	);

	axi_rd_slave_model slave_i (
		.ACLK(ACLK), .ARESETn(ARESETn), .ar(ar), .ARVALID(ARVALID),
		.ARREADY(ARREADY), .r(r), .RVALID(RVALID), .RREADY(RREADY)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] a);
		return lcg_step(lcg_step({a[31:2], 2'b00} ^ 32'he287_f19f));
	endfunction

	// expected load result from memory word, lane and error rules
	function automatic cpu_defs_pkg::load_res_t expected_result(
		input cpu_defs_pkg::load_req_t q);
		cpu_defs_pkg::load_res_t e;
		logic [31:0]             w;
		logic [7:0]              b;
		logic [15:0]             h;
		w = word_at(q.addr);
		b = 8'(w >> {q.addr[1:0], 3'b000});
		h = 16'(w >> {q.addr[1], 4'b0000});
		if (q.size == cpu_defs_pkg::ld_byte) begin
			e.data = {{24{q.sgn && b[7]}}, b};
		end else if (q.size == cpu_defs_pkg::ld_half) begin
			e.data = {{16{q.sgn && h[15]}}, h};
		end else begin
			e.data = w;
		end
		e.id  = q.id;
		e.err = q.addr[31];
		return e;
	endfunction

	initial begin
		ACLK = 1'b0;
		forever #10 ACLK = ~ACLK;
	end

	always @(posedge ACLK) cyc <= cyc + 1;

	initial begin
		#(budget_ns);
		$display("timeout: loads did not complete within the time budget");
		$display("TB FAILED");
		$finish;
	end

	////////////////////
	// response checks
	////////////////////

	always @(negedge ACLK) begin
		if (raddr_ok) raddr_cnt++;
		if (block_chk) begin
			assert (!(ARVALID && ARREADY)) else begin
				$display("AR handshake happened while a store to the same word was busy");
				err_cnt++;
			end
		end
		// AXI encodings, one beat of four bytes, FIXED burst, word aligned
		if (ARVALID && ARREADY) begin
			assert (ar.len === 8'h00) else begin
				$display("CHECK FAILED ar.len exp %h got %h", 8'h00, ar.len);
				err_cnt++;
			end
			assert (ar.size === 3'b010) else begin
				$display("CHECK FAILED ar.size exp %h got %h", 3'b010, ar.size);
				err_cnt++;
			end
			assert (ar.burst === 2'b00) else begin
				$display("CHECK FAILED ar.burst exp %h got %h", 2'b00, ar.burst);
				err_cnt++;
			end
			assert (ar.addr[1:0] === 2'b00) else begin
				$display("CHECK FAILED ar.addr[1:0] exp %h got %h", 2'b00, ar.addr[1:0]);
				err_cnt++;
			end
		end
		if (rdata_ok) begin
			if (exp_q.size() == 0) begin
				$display("rdata_ok pulsed with no load outstanding");
				err_cnt++;
			end else begin
				exp_res = exp_q.pop_front();
				assert (res.data === exp_res.data) else begin
					$display("CHECK FAILED res.data exp %h got %h", exp_res.data, res.data);
					err_cnt++;
				end
				assert (res.id === exp_res.id) else begin
					$display("CHECK FAILED res.id exp %h got %h", exp_res.id, res.id);
					err_cnt++;
				end
				assert (res.err === exp_res.err) else begin
					$display("CHECK FAILED res.err exp %h got %h", exp_res.err, res.err);
					err_cnt++;
				end
			end
		end
	end

	task automatic issue_load(input logic [31:0] a, input logic [1:0] sz, input logic sg);
		cpu_defs_pkg::load_req_t q;
		@(posedge ACLK);
		#2;
		while (!req_ready) begin
			@(posedge ACLK);
			#2;
		end
		q.addr = a;
		q.id   = next_id;
		q.size = sz;
		q.sgn  = sg;
		next_id = next_id + 4'd1;
		req = q;
		ren = 1'b1;
		exp_q.push_back(expected_result(q));
		accept_cnt++;
		@(posedge ACLK);
		#2;
		ren = 1'b0;
		assert (raddr_ok === 1'b1) else begin
			$display("CHECK FAILED raddr_ok exp 1 got %h", raddr_ok);
			err_cnt++;
		end
	endtask

	// strobe while busy, must be ignored
	task automatic stray_strobe();
		@(posedge ACLK);
		#2;
		while (req_ready) begin
			@(posedge ACLK);
			#2;
		end
		req.addr = 32'h0000_0100;
		req.id   = 4'hf;
		ren = 1'b1;
		@(posedge ACLK);
		#2;
		ren = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0) @(posedge ACLK);
		@(posedge ACLK);
		#2;
	endtask

	task automatic random_load(input logic err_region);
		logic [31:0] a;
		logic [1:0]  sz;
		rng = lcg_step(rng);
		a   = {err_region, rng[30:2], 2'b00};
		sz  = (rng[1:0] == 2'd3) ? cpu_defs_pkg::ld_word : rng[1:0];
		rng = lcg_step(rng);
		if (sz == cpu_defs_pkg::ld_byte) a[1:0] = rng[9:8];
		if (sz == cpu_defs_pkg::ld_half) a[1] = rng[9];
		issue_load(a, sz, rng[12]);
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == test_err0) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, err_cnt - test_err0);
		end
		test_err0 = err_cnt;
	endtask

	initial begin
		int t0;
		ARESETn = 1'b0;
		ren = 1'b0;
		req = '0;
		store = '0;
		rng = 32'he287_f19f;
		next_id = 4'd0;
		block_chk = 1'b0;
		err_cnt = 0;
		test_err0 = 0;
		tests_ok = 0;
		tests_bad = 0;
		accept_cnt = 0;
		raddr_cnt = 0;
		cyc = 0;
		repeat (2) @(posedge ACLK);
		#2;
		ARESETn = 1'b1;
		assert (!ARVALID && !RREADY && !raddr_ok && !rdata_ok && req_ready) else begin
			$display("CHECK FAILED reset ARVALID %h RREADY %h raddr_ok %h rdata_ok %h req_ready %h",
				ARVALID, RREADY, raddr_ok, rdata_ok, req_ready);
			err_cnt++;
		end
		finish_test("reset_state");

		// every size, offset and sign mode
		for (int sg = 0; sg < 2; sg++) begin
			for (int o = 0; o < 4; o++) begin
				issue_load(32'h0000_1230 + o, cpu_defs_pkg::ld_byte, 1'(sg));
			end
			issue_load(32'h0000_2470, cpu_defs_pkg::ld_half, 1'(sg));
			issue_load(32'h0000_2472, cpu_defs_pkg::ld_half, 1'(sg));
			issue_load(32'h0000_36a8, cpu_defs_pkg::ld_word, 1'(sg));
		end
		wait_idle();
		finish_test("lanes");

		for (int i = 0; i < 4; i++) begin
			issue_load(32'h0000_4000 + 4 * i, cpu_defs_pkg::ld_word, 1'b0);
			stray_strobe();
		end
		wait_idle();
		assert (raddr_cnt == accept_cnt) else begin
			$display("CHECK FAILED raddr_ok count exp %h got %h", accept_cnt, raddr_cnt);
			err_cnt++;
		end
		finish_test("ignored_strobes");

		////////////////////
		// store hazard
		////////////////////
		store.busy  = 1'b1;
		store.waddr = 30'h0000_1600;
		issue_load(32'h0000_5802, cpu_defs_pkg::ld_half, 1'b1);
		block_chk = 1'b1;
		repeat (12) @(posedge ACLK);
		#2;
		block_chk  = 1'b0;
		store.busy = 1'b0;
		wait_idle();
		store.busy  = 1'b1;
		store.waddr = 30'h0000_1601;
		t0 = cyc;
		issue_load(32'h0000_5800, cpu_defs_pkg::ld_word, 1'b0);
		wait_idle();
		store.busy = 1'b0;
		assert (cyc - t0 < 16) else begin
			$display("load to a different word was held up by the store");
			err_cnt++;
		end
		finish_test("store_hazard");

		for (int i = 0; i < 200; i++) random_load(1'b0);
		wait_idle();
		finish_test("random_200");

		for (int i = 0; i < 8; i++) random_load(1'(i % 2));
		wait_idle();
		finish_test("error_region");

		$display("tests ok %0d, tests failed %0d, failed checks %0d",
			tests_ok, tests_bad, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* axi_rd_bridge_top.f */
logic/axi_defs_pkg.sv
logic/cpu_defs_pkg.sv
logic/load_req_gate.sv
logic/axi_rd_master.sv
logic/load_result_align.sv
logic/axi_rd_bridge_top.sv
dv/axi_rd_slave_model.sv
dv/axi_rd_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
	-f axi_rd_bridge_top.f \
	--top-module axi_rd_bridge_tb \
	-o axi_rd_bridge_sim

./obj_dir/axi_rd_bridge_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
